// File: common/fft_types_pkg.sv
package fft_types_pkg;

    // default sample width, Q1.15
    localparam int SAMPLE_W = 16;

    // transform length and width of a point index
    localparam int N_POINTS = 8;
    localparam int IDX_W = 3;

    // twiddle format: signed, FRAC_W fraction bits
    localparam int FRAC_W = 15;
    localparam int TW_W = FRAC_W + 1;

    // twiddle table index, one of the four W8^k values
    localparam int TW_IDX_W = 2;

endpackage

// File: common/fft_twiddle_pkg.sv
package fft_twiddle_pkg;

    // W8^k = cos(2*pi*k/8) - j*sin(2*pi*k/8), k = 0..3, Q1.15
    localparam logic signed [15:0] TW_RE [0:3] = '{
        16'sd32767,
        16'sd23170,
        16'sd0,
        -16'sd23170
    };

    localparam logic signed [15:0] TW_IM [0:3] = '{
        16'sd0,
        -16'sd23170,
        -16'sd32767,
        -16'sd23170
    };

    // three radix-2 stages, each split into two passes of two butterflies
    localparam int N_STAGES = 3;
    localparam int N_PASSES = 2;

    // sequencer states
    typedef enum logic [1:0] {
        ST_IDLE = 2'b00,
        ST_LOAD = 2'b01,
        ST_CALC = 2'b10,
        ST_DONE = 2'b11
    } ctrl_state_t;

endpackage

// File: fft/fft_butterfly.sv
`timescale 1ns/100ps

module fft_butterfly #(
    parameter int DATA_W = 16
) (
    input  logic signed [DATA_W-1:0]              a_re,
    input  logic signed [DATA_W-1:0]              a_im,
    input  logic signed [DATA_W-1:0]              b_re,
    input  logic signed [DATA_W-1:0]              b_im,
    input  logic signed [fft_types_pkg::TW_W-1:0] w_re,
    input  logic signed [fft_types_pkg::TW_W-1:0] w_im,
    output logic signed [DATA_W-1:0]              sum_re,
    output logic signed [DATA_W-1:0]              sum_im,
    output logic signed [DATA_W-1:0]              dif_re,
    output logic signed [DATA_W-1:0]              dif_im
);

    // full product width plus one bit for the add of two products
    localparam int PROD_W = DATA_W + fft_types_pkg::TW_W;
    localparam int BW_W = PROD_W + 1 - fft_types_pkg::FRAC_W;

    logic signed [PROD_W:0]   bw_re_full;
    logic signed [PROD_W:0]   bw_im_full;
    logic signed [BW_W-1:0]   bw_re;
    logic signed [BW_W-1:0]   bw_im;
    logic signed [BW_W:0]     sum_re_full;
    logic signed [BW_W:0]     sum_im_full;
    logic signed [BW_W:0]     dif_re_full;
    logic signed [BW_W:0]     dif_im_full;

    // complex multiply b * w
    always_comb begin
        bw_re_full = b_re * w_re - b_im * w_im;
        bw_im_full = b_re * w_im + b_im * w_re;
    end

    // back to sample scale, truncating
    assign bw_re = BW_W'(bw_re_full >>> fft_types_pkg::FRAC_W);
    assign bw_im = BW_W'(bw_im_full >>> fft_types_pkg::FRAC_W);

    always_comb begin
        sum_re_full = a_re + bw_re;
        sum_im_full = a_im + bw_im;
        dif_re_full = a_re - bw_re;
        dif_im_full = a_im - bw_im;
    end

    // halve every result so three stages give DFT/8
    assign sum_re = DATA_W'(sum_re_full >>> 1);
    assign sum_im = DATA_W'(sum_im_full >>> 1);
    assign dif_re = DATA_W'(dif_re_full >>> 1);
    assign dif_im = DATA_W'(dif_im_full >>> 1);

endmodule

// File: fft/fft_stage_ctrl.sv
`timescale 1ns/100ps

module fft_stage_ctrl (
    input  logic       clk,
    input  logic       reset,
    input  logic       start,
    output logic       load,
    output logic       calc,
    output logic [1:0] stage,
    output logic       pass,
    output logic       done
);

    localparam logic [1:0] LAST_STAGE = 2'(fft_twiddle_pkg::N_STAGES - 1);
    localparam logic       LAST_PASS = 1'(fft_twiddle_pkg::N_PASSES - 1);

    fft_twiddle_pkg::ctrl_state_t state;
    fft_twiddle_pkg::ctrl_state_t state_d;

    logic [1:0] stage_q;
    logic       pass_q;
    logic       done_q;
    logic       calc_last;

    assign calc_last = (stage_q == LAST_STAGE) && (pass_q == LAST_PASS);

    always_comb begin
        state_d = state;
        case (state)
            fft_twiddle_pkg::ST_IDLE: begin
                if (start) begin
                    state_d = fft_twiddle_pkg::ST_LOAD;
                end
            end
            fft_twiddle_pkg::ST_LOAD: begin
                state_d = fft_twiddle_pkg::ST_CALC;
            end
            fft_twiddle_pkg::ST_CALC: begin
                if (calc_last) begin
                    state_d = fft_twiddle_pkg::ST_DONE;
                end
            end
            fft_twiddle_pkg::ST_DONE: begin
                // hold results until start is released
                if (!start) begin
                    state_d = fft_twiddle_pkg::ST_IDLE;
                end
            end
            default: state_d = fft_twiddle_pkg::ST_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= fft_twiddle_pkg::ST_IDLE;
            stage_q <= 2'd0;
            pass_q <= 1'b0;
            done_q <= 1'b0;
        end else begin
            state <= state_d;
            // done lags the DONE state by one edge, drops with start
            done_q <= (state == fft_twiddle_pkg::ST_DONE) && start;
            if (state == fft_twiddle_pkg::ST_CALC) begin
                if (pass_q == LAST_PASS) begin
                    pass_q <= 1'b0;
                    stage_q <= calc_last ? 2'd0 : stage_q + 2'd1;
                end else begin
                    pass_q <= pass_q + 1'b1;
                end
            end
        end
    end

    assign load = (state == fft_twiddle_pkg::ST_LOAD);
    assign calc = (state == fft_twiddle_pkg::ST_CALC);
    assign stage = stage_q;
    assign pass = pass_q;
    assign done = done_q;

    a_done_not_calc: assert property (@(posedge clk) disable iff (reset) !(done && calc));

    a_stage_range: assert property (@(posedge clk) disable iff (reset) stage <= LAST_STAGE);

endmodule

// File: fft/fft_data_regs.sv
`timescale 1ns/100ps

module fft_data_regs #(
    parameter int DATA_W = 16
) (
    input  logic                                  clk,
    input  logic                                  reset,
    input  logic                                  load,
    input  logic                                  calc,
    input  logic [1:0]                            stage,
    input  logic                                  pass,
    input  logic signed [DATA_W-1:0]              x_re [0:fft_types_pkg::N_POINTS-1],
    input  logic signed [DATA_W-1:0]              x_im [0:fft_types_pkg::N_POINTS-1],
    input  logic signed [DATA_W-1:0]              sum0_re,
    input  logic signed [DATA_W-1:0]              sum0_im,
    input  logic signed [DATA_W-1:0]              dif0_re,
    input  logic signed [DATA_W-1:0]              dif0_im,
    input  logic signed [DATA_W-1:0]              sum1_re,
    input  logic signed [DATA_W-1:0]              sum1_im,
    input  logic signed [DATA_W-1:0]              dif1_re,
    input  logic signed [DATA_W-1:0]              dif1_im,
    output logic signed [DATA_W-1:0]              a0_re,
    output logic signed [DATA_W-1:0]              a0_im,
    output logic signed [DATA_W-1:0]              b0_re,
    output logic signed [DATA_W-1:0]              b0_im,
    output logic signed [fft_types_pkg::TW_W-1:0] w0_re,
    output logic signed [fft_types_pkg::TW_W-1:0] w0_im,
    output logic signed [DATA_W-1:0]              a1_re,
    output logic signed [DATA_W-1:0]              a1_im,
    output logic signed [DATA_W-1:0]              b1_re,
    output logic signed [DATA_W-1:0]              b1_im,
    output logic signed [fft_types_pkg::TW_W-1:0] w1_re,
    output logic signed [fft_types_pkg::TW_W-1:0] w1_im,
    output logic signed [DATA_W-1:0]              y_re [0:fft_types_pkg::N_POINTS-1],
    output logic signed [DATA_W-1:0]              y_im [0:fft_types_pkg::N_POINTS-1]
);

    localparam int N = fft_types_pkg::N_POINTS;
    localparam int IW = fft_types_pkg::IDX_W;
    localparam int TIW = fft_types_pkg::TW_IDX_W;

    logic signed [DATA_W-1:0] bank_re [0:N-1];
    logic signed [DATA_W-1:0] bank_im [0:N-1];

    logic [IW-1:0]  top0;
    logic [IW-1:0]  bot0;
    logic [IW-1:0]  top1;
    logic [IW-1:0]  bot1;
    logic [TIW-1:0] tw0;
    logic [TIW-1:0] tw1;

    function automatic logic [IW-1:0] bit_rev(input logic [IW-1:0] idx);
        logic [IW-1:0] r;
        for (int i = 0; i < IW; i++) begin
            r[i] = idx[IW-1-i];
        end
        return r;
    endfunction

    // butterfly k of stage s, span h = 2^s: top = g*2h + j
    function automatic logic [IW-1:0] top_index(input logic [1:0] stg, input logic [1:0] k);
        logic [IW-1:0] kk;
        logic [IW-1:0] mask;
        logic [IW-1:0] grp;
        kk = IW'(k);
        mask = IW'((1 << stg) - 1);
        grp = kk >> stg;
        return IW'(grp << (stg + 1)) | (kk & mask);
    endfunction

    // twiddle index j * (4/h)
    function automatic logic [TIW-1:0] tw_index(input logic [1:0] stg, input logic [1:0] k);
        logic [1:0] mask;
        mask = 2'((1 << stg) - 1);
        return TIW'((k & mask) << (2 - stg));
    endfunction

    // pass p serves k = 2p on unit 0 and k = 2p+1 on unit 1
    always_comb begin
        top0 = top_index(stage, {pass, 1'b0});
        top1 = top_index(stage, {pass, 1'b1});
        bot0 = top0 + IW'(1 << stage);
        bot1 = top1 + IW'(1 << stage);
        tw0 = tw_index(stage, {pass, 1'b0});
        tw1 = tw_index(stage, {pass, 1'b1});
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < N; i++) begin
                bank_re[i] <= '0;
                bank_im[i] <= '0;
            end
        end else if (load) begin
            // DIT wants the inputs in bit-reversed order
            for (int i = 0; i < N; i++) begin
                bank_re[bit_rev(IW'(i))] <= x_re[i];
                bank_im[bit_rev(IW'(i))] <= x_im[i];
            end
        end else if (calc) begin
            // in place write back of both butterflies
            bank_re[top0] <= sum0_re;
            bank_im[top0] <= sum0_im;
            bank_re[bot0] <= dif0_re;
            bank_im[bot0] <= dif0_im;
            bank_re[top1] <= sum1_re;
            bank_im[top1] <= sum1_im;
            bank_re[bot1] <= dif1_re;
            bank_im[bot1] <= dif1_im;
        end
    end

    assign a0_re = bank_re[top0];
    assign a0_im = bank_im[top0];
    assign b0_re = bank_re[bot0];
    assign b0_im = bank_im[bot0];
    assign w0_re = fft_twiddle_pkg::TW_RE[tw0];
    assign w0_im = fft_twiddle_pkg::TW_IM[tw0];

    assign a1_re = bank_re[top1];
    assign a1_im = bank_im[top1];
    assign b1_re = bank_re[bot1];
    assign b1_im = bank_im[bot1];
    assign w1_re = fft_twiddle_pkg::TW_RE[tw1];
    assign w1_im = fft_twiddle_pkg::TW_IM[tw1];

    // natural frequency order after the last stage
    assign y_re = bank_re;
    assign y_im = bank_im;

    a_pairs_disjoint: assert property (@(posedge clk) disable iff (reset)
        calc |-> (top0 != top1) && (top0 != bot1) && (bot0 != top1) && (bot0 != bot1));

endmodule

// File: src/fft8_top.sv
`timescale 1ns/100ps

module fft8_top #(
    parameter int DATA_W = fft_types_pkg::SAMPLE_W
) (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     start,
    input  logic signed [DATA_W-1:0] x_re [0:fft_types_pkg::N_POINTS-1],
    input  logic signed [DATA_W-1:0] x_im [0:fft_types_pkg::N_POINTS-1],
    output logic signed [DATA_W-1:0] y_re [0:fft_types_pkg::N_POINTS-1],
    output logic signed [DATA_W-1:0] y_im [0:fft_types_pkg::N_POINTS-1],
    output logic                     done
);

    localparam int TW_W = fft_types_pkg::TW_W;

    logic       load;
    logic       calc;
    logic [1:0] stage;
    logic       pass;

    // butterfly unit 0
    logic signed [DATA_W-1:0] a0_re, a0_im, b0_re, b0_im;
    logic signed [TW_W-1:0]   w0_re, w0_im;
    logic signed [DATA_W-1:0] sum0_re, sum0_im, dif0_re, dif0_im;

    // butterfly unit 1
    logic signed [DATA_W-1:0] a1_re, a1_im, b1_re, b1_im;
    logic signed [TW_W-1:0]   w1_re, w1_im;
    logic signed [DATA_W-1:0] sum1_re, sum1_im, dif1_re, dif1_im;

    fft_stage_ctrl u_ctrl (
        .clk   (clk),
        .reset (reset),
        .start (start),
        .load  (load),
        .calc  (calc),
        .stage (stage),
        .pass  (pass),
        .done  (done)
    );

    fft_data_regs #(.DATA_W(DATA_W)) u_regs (
        .clk     (clk),
        .reset   (reset),
        .load    (load),
        .calc    (calc),
        .stage   (stage),
        .pass    (pass),
        .x_re    (x_re),
        .x_im    (x_im),
        .sum0_re (sum0_re),
        .sum0_im (sum0_im),
        .dif0_re (dif0_re),
        .dif0_im (dif0_im),
        .sum1_re (sum1_re),
        .sum1_im (sum1_im),
        .dif1_re (dif1_re),
        .dif1_im (dif1_im),
        .a0_re   (a0_re),
        .a0_im   (a0_im),
        .b0_re   (b0_re),
        .b0_im   (b0_im),
        .w0_re   (w0_re),
        .w0_im   (w0_im),
        .a1_re   (a1_re),
        .a1_im   (a1_im),
        .b1_re   (b1_re),
        .b1_im   (b1_im),
        .w1_re   (w1_re),
        .w1_im   (w1_im),
        .y_re    (y_re),
        .y_im    (y_im)
    );

    fft_butterfly #(.DATA_W(DATA_W)) u_bfly0 (
        .a_re   (a0_re),
        .a_im   (a0_im),
        .b_re   (b0_re),
        .b_im   (b0_im),
        .w_re   (w0_re),
        .w_im   (w0_im),
        .sum_re (sum0_re),
        .sum_im (sum0_im),
        .dif_re (dif0_re),
        .dif_im (dif0_im)
    );

    fft_butterfly #(.DATA_W(DATA_W)) u_bfly1 (
        .a_re   (a1_re),
        .a_im   (a1_im),
        .b_re   (b1_re),
        .b_im   (b1_im),
        .w_re   (w1_re),
        .w_im   (w1_im),
        .sum_re (sum1_re),
        .sum_im (sum1_im),
        .dif_re (dif1_re),
        .dif_im (dif1_im)
    );

endmodule

// File: tb/fft8_ref_model.svh
`ifndef FFT8_REF_MODEL_SVH
`define FFT8_REF_MODEL_SVH

// W8^k in Q1.15, real part
function automatic longint twiddle_re(input int k);
    case (k)
        0: return 32767;
        1: return 23170;
        2: return 0;
        default: return -23170;
    endcase
endfunction

// W8^k in Q1.15, imaginary part
function automatic longint twiddle_im(input int k);
    case (k)
        0: return 0;
        1: return -23170;
        2: return -32767;
        default: return -23170;
    endcase
endfunction

// 3-bit index reversal
function automatic int reverse3(input int idx);
    return ((idx & 1) << 2) | (idx & 2) | ((idx >> 2) & 1);
endfunction

// keep the low DATA_W bits as a signed value
function automatic longint wrap_sample(input longint v);
    longint m;
    m = v & ((longint'(1) << DATA_W) - 1);
    if (m >= (longint'(1) << (DATA_W - 1))) begin
        m = m - (longint'(1) << DATA_W);
    end
    return m;
endfunction

// in place radix-2 DIT on stim_re/stim_im, result into exp_re/exp_im
task automatic compute_expected();
    longint wr [0:7];
    longint wi [0:7];
    longint pr;
    longint pi;
    longint ar;
    longint ai;
    int top;
    int bot;
    int tw;
    for (int i = 0; i < 8; i++) begin
        wr[reverse3(i)] = stim_re[i];
        wi[reverse3(i)] = stim_im[i];
    end
    for (int h = 1; h < 8; h = h * 2) begin
        for (int k = 0; k < 4; k++) begin
            top = (k / h) * 2 * h + (k % h);
            bot = top + h;
            tw = (k % h) * (4 / h);
            pr = wr[bot] * twiddle_re(tw) - wi[bot] * twiddle_im(tw);
            pi = wr[bot] * twiddle_im(tw) + wi[bot] * twiddle_re(tw);
            pr = pr >>> fft_types_pkg::FRAC_W;
            pi = pi >>> fft_types_pkg::FRAC_W;
            ar = wr[top];
            ai = wi[top];
            wr[top] = wrap_sample((ar + pr) >>> 1);
            wi[top] = wrap_sample((ai + pi) >>> 1);
            wr[bot] = wrap_sample((ar - pr) >>> 1);
            wi[bot] = wrap_sample((ai - pi) >>> 1);
        end
    end
    for (int i = 0; i < 8; i++) begin
        exp_re[i] = DATA_W'(wr[i]);
        exp_im[i] = DATA_W'(wi[i]);
    end
endtask

`endif

// File: tb/fft8_tb.sv
`timescale 1ns/100ps

module fft8_tb;

    localparam int DATA_W = fft_types_pkg::SAMPLE_W;
    localparam int N = fft_types_pkg::N_POINTS;
    localparam int LATENCY = 9;
    localparam int DONE_TIMEOUT = 50;

    logic                     clk;
    logic                     reset;
    logic                     start;
    logic signed [DATA_W-1:0] x_re [0:N-1];
    logic signed [DATA_W-1:0] x_im [0:N-1];
    logic signed [DATA_W-1:0] y_re [0:N-1];
    logic signed [DATA_W-1:0] y_im [0:N-1];
    logic                     done;

    // next input set and the model's answer for it
    logic signed [DATA_W-1:0] stim_re [0:N-1];
    logic signed [DATA_W-1:0] stim_im [0:N-1];
    logic signed [DATA_W-1:0] exp_re [0:N-1];
    logic signed [DATA_W-1:0] exp_im [0:N-1];
    logic [15:0]              lfsr;

    `include "fft8_ref_model.svh"

    fft8_top #(.DATA_W(DATA_W)) u_fft8_top (
        .clk   (clk),
        .reset (reset),
        .start (start),
        .x_re  (x_re),
        .x_im  (x_im),
        .y_re  (y_re),
        .y_im  (y_im),
        .done  (done)
    );

    always #20 clk = ~clk;

    task automatic stop_run();
        $display("RESULT: FAIL");
        $fatal(1, "stopping at the first error");
    endtask

    task automatic report_timeout(input string what);
        $display("timeout at time %0t: done did not rise within %0d cycles (%s)",
                 $time, DONE_TIMEOUT, what);
        stop_run();
    endtask

    task automatic compare_sample(input logic signed [DATA_W-1:0] got,
                                  input logic signed [DATA_W-1:0] expv,
                                  input int idx, input string what);
        if (got !== expv) begin
            $display("FAILED at time %0t: %s[%0d] is %0d, expected %0d",
                     $time, what, idx, got, expv);
            stop_run();
        end
    endtask

    task automatic compare_done(input logic got, input logic expv, input string what);
        if (got !== expv) begin
            $display("FAILED at time %0t: %s, done is %b, expected %b",
                     $time, what, got, expv);
            stop_run();
        end
    endtask

    task automatic compare_latency(input int got, input int expv, input string what);
        if (got != expv) begin
            $display("FAILED at time %0t: %s, latency %0d cycles, expected %0d",
                     $time, what, got, expv);
            stop_run();
        end
    endtask

    // taps for x^16 + x^14 + x^13 + x^11
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic random_sample(output logic signed [DATA_W-1:0] v);
        for (int i = 0; i < DATA_W; i++) begin
            v[i] = lfsr[15];
            lfsr = lfsr_step(lfsr);
        end
    endtask

    task automatic fill_random_stim();
        for (int i = 0; i < N; i++) begin
            random_sample(stim_re[i]);
            random_sample(stim_im[i]);
        end
    endtask

    task automatic drive_stim();
        for (int i = 0; i < N; i++) begin
            x_re[i] <= stim_re[i];
            x_im[i] <= stim_im[i];
        end
    endtask

    // random garbage on x only
    task automatic scramble_inputs();
        logic signed [DATA_W-1:0] v;
        for (int i = 0; i < N; i++) begin
            random_sample(v);
            x_re[i] <= v;
            random_sample(v);
            x_im[i] <= v;
        end
    endtask

    task automatic start_transform();
        @(posedge clk);
        drive_stim();
        start <= 1'b1;
    endtask

    // counts low samples of done after the start was driven
    task automatic wait_for_done(output int cycles, input logic scramble);
        cycles = 0;
        @(negedge clk);
        while (!done) begin
            cycles++;
            if (cycles > DONE_TIMEOUT) begin
                report_timeout("waiting for a transform");
            end
            @(posedge clk);
            // load edge is past once two edges went by
            if (scramble && cycles >= 2) begin
                scramble_inputs();
            end
            @(negedge clk);
        end
    endtask

    task automatic check_outputs(input string what);
        compute_expected();
        for (int i = 0; i < N; i++) begin
            compare_sample(y_re[i], exp_re[i], i, {what, " y_re"});
            compare_sample(y_im[i], exp_im[i], i, {what, " y_im"});
        end
    endtask

    task automatic run_transform(input string what, output int cycles);
        start_transform();
        wait_for_done(cycles, 1'b0);
        check_outputs(what);
    endtask

    task automatic release_start();
        @(posedge clk);
        start <= 1'b0;
        @(negedge clk);
        compare_done(done, 1'b1, "done in the cycle start fell");
        @(negedge clk);
        compare_done(done, 1'b0, "done one edge after start fell");
    endtask

    // results must hold while start stays high and x moves
    task automatic hold_with_start_high(input int n);
        repeat (n) begin
            @(posedge clk);
            scramble_inputs();
            @(negedge clk);
            compare_done(done, 1'b1, "done while start held");
            for (int i = 0; i < N; i++) begin
                compare_sample(y_re[i], exp_re[i], i, "held y_re");
                compare_sample(y_im[i], exp_im[i], i, "held y_im");
            end
        end
    endtask

    task automatic idle_after_reset();
        @(negedge clk);
        compare_done(done, 1'b0, "done after reset");
        for (int i = 0; i < N; i++) begin
            compare_sample(y_re[i], '0, i, "y_re after reset");
            compare_sample(y_im[i], '0, i, "y_im after reset");
        end
    endtask

    task automatic impulse_and_constant();
        int cycles;
        for (int i = 0; i < N; i++) begin
            stim_re[i] = '0;
            stim_im[i] = '0;
        end
        // impulse of 0.5 at x[0]
        stim_re[0] = DATA_W'(1 << (DATA_W - 2));
        run_transform("impulse", cycles);
        // every bin holds the impulse divided by 8
        for (int i = 0; i < N; i++) begin
            compare_sample(y_re[i], stim_re[0] >>> 3, i, "impulse bins equal, y_re");
            compare_sample(y_im[i], '0, i, "impulse bins equal, y_im");
        end
        release_start();
        for (int i = 0; i < N; i++) begin
            stim_re[i] = DATA_W'(1 << (DATA_W - 3));
            stim_im[i] = -DATA_W'(1 << (DATA_W - 4));
        end
        run_transform("constant", cycles);
        // all energy lands in bin 0
        for (int i = 1; i < N; i++) begin
            compare_sample(y_re[i], '0, i, "constant y_re");
            compare_sample(y_im[i], '0, i, "constant y_im");
        end
        release_start();
    endtask

    task automatic random_input_sets();
        int cycles;
        repeat (20) begin
            fill_random_stim();
            run_transform("random", cycles);
            release_start();
        end
    endtask

    task automatic handshake_timing();
        int cycles;
        fill_random_stim();
        run_transform("timing", cycles);
        compare_latency(cycles, LATENCY, "start edge to done");
        hold_with_start_high(12);
        release_start();
    endtask

    task automatic input_isolation();
        int cycles;
        fill_random_stim();
        start_transform();
        wait_for_done(cycles, 1'b1);
        compare_latency(cycles, LATENCY, "with inputs moving");
        check_outputs("inputs moved during calc");
        // long enough for two transforms but only one may run
        hold_with_start_high(2 * LATENCY + 4);
        release_start();
        repeat (3) begin
            @(negedge clk);
            compare_done(done, 1'b0, "done while idle");
        end
        fill_random_stim();
        run_transform("after restart", cycles);
        compare_latency(cycles, LATENCY, "after restart");
        release_start();
    endtask

    initial begin
        clk = 1'b0;
        reset = 1'b1;
        start = 1'b0;
        lfsr = 16'd19725;
        for (int i = 0; i < N; i++) begin
            x_re[i] = '0;
            x_im[i] = '0;
        end
        repeat (8) @(posedge clk);
        reset <= 1'b0;

        idle_after_reset();
        impulse_and_constant();
        random_input_sets();
        handshake_timing();
        input_isolation();

        $display("RESULT: PASS");
        $finish;
    end

endmodule

// File: fft8.f
+incdir+tb
common/fft_types_pkg.sv
common/fft_twiddle_pkg.sv
fft/fft_butterfly.sv
fft/fft_stage_ctrl.sv
fft/fft_data_regs.sv
src/fft8_top.sv
tb/fft8_tb.sv

// File: run_sim.sh
#!/bin/sh
# Compile and run the FFT testbench with Verilator.
# Exits non-zero on a compile error, a simulation error or a missing pass line.

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BIN=fft8_sim

rm -rf obj_dir "$LOG"

verilator --binary --timing -Wno-fatal --top-module fft8_tb -f fft8.f -o "$BIN"
if [ $? -ne 0 ]; then
    echo "Verilator compile failed"
    exit 1
fi

./obj_dir/"$BIN" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^RESULT: PASS$" "$LOG"; then
    exit 0
fi
echo "pass line not found in $LOG"
exit 1
